/* Bender.yml */
package:
  name: ppu_pixel_path

sources:
  - files:
      - rtl/ppu_pkg.sv
      - rtl/ppu_cfg_decode.sv
      - rtl/ppu_blender.sv
      - rtl/ppu_palette_mapper.sv
      - rtl/ppu_raster_counter.sv
      - rtl/ppu_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ppu_tb.sv

/* bench/ppu_tb_check.svh */
// PPU testbench compare tasks
// Typed value checks for pixels, coordinates and single bits, and the
// common error exit used by every check and by the timeout

`ifndef PPU_TB_CHECK_SVH
`define PPU_TB_CHECK_SVH

// Common exit for any failed check
task automatic end_with_failure();
	$display("RESULT: FAIL");
	$fatal(1, "Simulation stopped on first error");
endtask

task automatic report_error(input string msg);
	$display("Error at %0t ns: %s", $time, msg);
	end_with_failure();
endtask

task automatic check_pix(input string name, input lcd_pix_t got, input lcd_pix_t exp);
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_coord(input string name, input coord_t got, input coord_t exp);
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end_with_failure();
	end
endtask

`endif

/* bench/ppu_tb.sv */
// PPU pixel path testbench
// Random layer beats from an LFSR, a credit-returning consumer, a
// reference model of blend, palette and LCD packing, and checks of
// flow control, beam position and halt on row start

`timescale 1ns/10ps

module ppu_tb import ppu_pkg::*; ();

	localparam int N_LAYERS    = 4;
	localparam int PX_CREDITS  = 4;
	localparam int PIX_W       = $bits(pix_t);
	localparam int CYCLE_LIMIT = 20000;

	logic                      clk_ppu = 1'b0;
	logic                      rst_n_ppu;
	logic                      cfg_wen_i;
	cfg_addr_t                 cfg_addr_i;
	cfg_data_t                 cfg_wdata_i;
	logic                      in_vld_i;
	logic                      in_rdy_o;
	logic [N_LAYERS-1:0]       layer_alpha_i;
	logic [N_LAYERS-1:0]       layer_paletted_i;
	logic [N_LAYERS*PIX_W-1:0] layer_pix_i;
	logic                      out_vld_o;
	lcd_pix_t                  out_pix_o;
	logic                      credit_i;
	logic                      running_o;
	coord_t                    beam_x_o;
	coord_t                    beam_y_o;

	`include "ppu_tb_check.svh"

	// Reference state
	pix_t       pal_model [256];
	pix_t       bg_model;
	lcd_pix_t   exp_q [$];
	int         sent_total = 0;
	int         owed = 0;
	int         cycles = 0;
	logic       hold_credits = 1'b0;
	logic [16:0] stim_lfsr = 17'd96561;
	logic [16:0] credit_lfsr = 17'd96561;

	ppu_core #(
		.N_LAYERS   (N_LAYERS),
		.PX_CREDITS (PX_CREDITS)
	) dut_i (
		.clk_ppu          (clk_ppu),
		.rst_n_ppu        (rst_n_ppu),
		.cfg_wen_i        (cfg_wen_i),
		.cfg_addr_i       (cfg_addr_i),
		.cfg_wdata_i      (cfg_wdata_i),
		.in_vld_i         (in_vld_i),
		.in_rdy_o         (in_rdy_o),
		.layer_alpha_i    (layer_alpha_i),
		.layer_paletted_i (layer_paletted_i),
		.layer_pix_i      (layer_pix_i),
		.out_vld_o        (out_vld_o),
		.out_pix_o        (out_pix_o),
		.credit_i         (credit_i),
		.running_o        (running_o),
		.beam_x_o         (beam_x_o),
		.beam_y_o         (beam_y_o)
	);

	always #5 clk_ppu = ~clk_ppu;

	// ------------------------------
	// Stimulus helpers
	// ------------------------------

	// x^17 + x^14 + 1, output taken from the top bit
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[14:0], stim_lfsr[16]};
		end
		return v;
	endfunction

	// Highest opaque layer wins, palette applied, then a zero goes in at bit 5
	function automatic lcd_pix_t expected_lcd(input logic [N_LAYERS-1:0] alpha,
			input logic [N_LAYERS-1:0] pal, input logic [N_LAYERS*PIX_W-1:0] pix);
		pix_t colour;
		logic found;
		colour = bg_model;
		found  = 1'b0;
		for (int i = N_LAYERS - 1; i >= 0; i--) begin
			if (!found && alpha[i]) begin
				found  = 1'b1;
				colour = pix[i*PIX_W +: PIX_W];
				if (pal[i])
					colour = pal_model[colour[7:0]];
			end
		end
		return {colour[14:5], 1'b0, colour[4:0]};
	endfunction

	task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
		@(negedge clk_ppu);
		cfg_wen_i   = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = data;
		@(negedge clk_ppu);
		cfg_wen_i   = 1'b0;
	endtask

	// Every 8th beat is fully transparent so the background shows
	task automatic send_beats(input int n, input logic use_pal);
		for (int b = 0; b < n; b++) begin
			@(negedge clk_ppu);
			for (int l = 0; l < N_LAYERS; l++)
				layer_pix_i[l*PIX_W +: PIX_W] = pix_t'(take_bits(PIX_W));
			layer_alpha_i    = (b % 8 == 7) ? '0 : N_LAYERS'(take_bits(N_LAYERS));
			layer_paletted_i = use_pal ? N_LAYERS'(take_bits(N_LAYERS)) : '0;
			in_vld_i         = 1'b1;
			do
				@(posedge clk_ppu);
			while (!(in_vld_i && in_rdy_o));
		end
		@(negedge clk_ppu);
		in_vld_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || owed != 0)
			@(posedge clk_ppu);
	endtask

	// ------------------------------
	// Monitors and consumer
	// ------------------------------

	always @(posedge clk_ppu) begin
		if (rst_n_ppu && in_vld_i && in_rdy_o)
			exp_q.push_back(expected_lcd(layer_alpha_i, layer_paletted_i, layer_pix_i));
	end

	// Beam must match the count of pixels sent so far, display 8 by 3
	always @(posedge clk_ppu) begin
		if (rst_n_ppu) begin
			check_coord("beam_x_o", beam_x_o, coord_t'(sent_total % 8));
			check_coord("beam_y_o", beam_y_o, coord_t'((sent_total / 8) % 3));
			if (out_vld_o) begin
				if (exp_q.size() == 0)
					report_error("a pixel left the DUT with no accepted beat outstanding");
				check_pix("out_pix_o", out_pix_o, exp_q.pop_front());
				sent_total++;
				owed++;
			end
		end
	end

	always @(negedge clk_ppu) begin
		credit_i = 1'b0;
		if (rst_n_ppu && !hold_credits && owed > 0) begin
			credit_lfsr = lfsr_step(credit_lfsr);
			if (credit_lfsr[16]) begin
				credit_i = 1'b1;
				owed--;
			end
		end
	end

	always @(posedge clk_ppu) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			end_with_failure();
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial begin
		int     base;
		pal_idx_t idx;
		rst_n_ppu        = 1'b0;
		cfg_wen_i        = 1'b0;
		cfg_addr_i       = '0;
		cfg_wdata_i      = '0;
		in_vld_i         = 1'b0;
		layer_alpha_i    = '0;
		layer_paletted_i = '0;
		layer_pix_i      = '0;
		credit_i         = 1'b0;
		repeat (2) @(negedge clk_ppu);
		rst_n_ppu = 1'b1;
		@(negedge clk_ppu);
		check_bit("running_o", running_o, 1'b0);
		check_bit("in_rdy_o", in_rdy_o, 1'b0);
		check_bit("out_vld_o", out_vld_o, 1'b0);
		check_coord("beam_x_o", beam_x_o, '0);
		check_coord("beam_y_o", beam_y_o, '0);

		// Display 8 by 3, random background, then run
		cfg_write(CFG_DISP_W, 16'd7);
		cfg_write(CFG_DISP_H, 16'd2);
		bg_model = pix_t'(take_bits(PIX_W));
		cfg_write(CFG_BG_COLOUR, {1'b0, bg_model});
		cfg_write(CFG_CTRL, 16'h0001);
		check_bit("running_o", running_o, 1'b1);

		send_beats(40, 1'b0);
		wait_idle();

		// Palette load starting mid-table so the pointer wraps
		cfg_write(CFG_PAL_IDX, 16'h0040);
		for (int i = 0; i < 256; i++) begin
			idx = pal_idx_t'(8'h40 + i);
			pal_model[idx] = pix_t'(take_bits(PIX_W));
			cfg_write(CFG_PAL_DATA, {1'b0, pal_model[idx]});
		end
		repeat (2) @(negedge clk_ppu);
		send_beats(40, 1'b1);
		wait_idle();

		// Credits withheld: only PX_CREDITS pixels may leave
		@(posedge clk_ppu);
		hold_credits = 1'b1;
		base = sent_total;
		fork
			send_beats(10, 1'b1);
		join_none
		repeat (30) @(negedge clk_ppu);
		if (sent_total - base != PX_CREDITS)
			report_error("pixel count with credits withheld differs from the credit limit");
		check_bit("out_vld_o", out_vld_o, 1'b0);
		check_bit("in_rdy_o", in_rdy_o, 1'b0);
		@(posedge clk_ppu);
		hold_credits = 1'b0;
		wait fork;
		wait_idle();

		// Halt on hsync stops the run at the next row start
		cfg_write(CFG_CTRL, 16'h0005);
		fork
			send_beats(24, 1'b1);
		join_none
		while (running_o)
			@(negedge clk_ppu);
		check_coord("beam_x_o", beam_x_o, '0);
		while (exp_q.size() != 0)
			@(negedge clk_ppu);
		repeat (20) begin
			@(negedge clk_ppu);
			check_bit("out_vld_o", out_vld_o, 1'b0);
			check_bit("running_o", running_o, 1'b0);
			check_bit("in_rdy_o", in_rdy_o, 1'b0);
		end
		cfg_write(CFG_CTRL, 16'h0001);
		check_bit("running_o", running_o, 1'b1);
		wait fork;
		wait_idle();

		repeat (5) @(negedge clk_ppu);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* build.f */
+incdir+bench
rtl/ppu_pkg.sv
rtl/ppu_cfg_decode.sv
rtl/ppu_blender.sv
rtl/ppu_palette_mapper.sv
rtl/ppu_raster_counter.sv
rtl/ppu_core.sv
bench/ppu_tb.sv

/* rtl/ppu_blender.sv */
// PPU blender, execute stage
// Picks the highest-numbered opaque layer pixel of each beat, or the
// default background colour when none is opaque, and registers it

`timescale 1ns/10ps

module ppu_blender import ppu_pkg::*; #(
	parameter int N_LAYERS = 4
) (
	input  logic                            clk_ppu,
	input  logic                            rst_n_ppu,

	input  logic                            run_i,

	input  logic                            in_vld_i,
	output logic                            in_rdy_o,
	input  logic [N_LAYERS-1:0]             layer_alpha_i,
	input  logic [N_LAYERS-1:0]             layer_paletted_i,
	input  logic [N_LAYERS*$bits(pix_t)-1:0] layer_pix_i,
	input  pix_t                            default_colour_i,

	output logic                            out_vld_o,
	input  logic                            out_rdy_i,
	output pix_t                            out_pix_o,
	output logic                            out_paletted_o
);

	localparam int PIX_W = $bits(pix_t);

	pix_t win_pix;
	logic win_paletted;
	logic accept;

	// Only take new beats while running; a held result still drains
	assign in_rdy_o = run_i && (!out_vld_o || out_rdy_i);
	assign accept   = in_vld_i && in_rdy_o;

	// Later layers overwrite earlier ones, so the highest opaque layer wins
	always_comb begin
		win_pix      = default_colour_i;
		win_paletted = 1'b0;
		for (int i = 0; i < N_LAYERS; i++) begin
			if (layer_alpha_i[i]) begin
				win_pix      = layer_pix_i[i*PIX_W +: PIX_W];
				win_paletted = layer_paletted_i[i];
			end
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			out_vld_o <= 1'b0;
		else if (accept)
			out_vld_o <= 1'b1;
		else if (out_rdy_i)
			out_vld_o <= 1'b0;
	end

	always_ff @(posedge clk_ppu) begin
		if (accept) begin
			out_pix_o      <= win_pix;
			out_paletted_o <= win_paletted;
		end
	end

	// Producer must hold a stalled beat until it is taken
	a_in_beat_stable: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		(in_vld_i && !in_rdy_o) |=> in_vld_i && $stable(layer_alpha_i) &&
		$stable(layer_paletted_i) && $stable(layer_pix_i));

endmodule

/* rtl/ppu_cfg_decode.sv */
// PPU configuration decode
// Turns write-only configuration writes into the background colour,
// display size and palette write strobes, and runs the run/halt
// controller, which can stop at the next row or frame start

`timescale 1ns/10ps

module ppu_cfg_decode import ppu_pkg::*; (
	input  logic      clk_ppu,
	input  logic      rst_n_ppu,

	input  logic      cfg_wen_i,
	input  cfg_addr_t cfg_addr_i,
	input  cfg_data_t cfg_wdata_i,

	input  logic      hsync_i,
	input  logic      vsync_i,

	output logic      run_o,
	output pix_t      default_colour_o,
	output coord_t    disp_w_o,
	output coord_t    disp_h_o,

	output logic      pal_wen_o,
	output pal_idx_t  pal_waddr_o,
	output pix_t      pal_wdata_o
);

	ppu_state_e state_q;
	ppu_state_e state_d;

	logic     halt_hsync_q;
	logic     halt_vsync_q;
	pal_idx_t pal_ptr_q;

	logic ctrl_wr;
	logic run_stb;
	logic halt_stb;
	logic sync_stop;
	logic pal_data_wr;

	assign ctrl_wr     = cfg_wen_i && (cfg_addr_i == CFG_CTRL);
	assign run_stb     = ctrl_wr && cfg_wdata_i[0];
	assign halt_stb    = ctrl_wr && cfg_wdata_i[1];
	assign pal_data_wr = cfg_wen_i && (cfg_addr_i == CFG_PAL_DATA);

	// Sync flags come straight from the raster advance so the stop lands on the wrap edge
	assign sync_stop = (halt_hsync_q && hsync_i) || (halt_vsync_q && vsync_i);

	// ------------------------------
	// Configuration registers
	// ------------------------------

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			halt_hsync_q     <= 1'b0;
			halt_vsync_q     <= 1'b0;
			default_colour_o <= '0;
			disp_w_o         <= '0;
			disp_h_o         <= '0;
			pal_ptr_q        <= '0;
			pal_wen_o        <= 1'b0;
		end else begin
			pal_wen_o <= pal_data_wr;
			if (ctrl_wr) begin
				halt_hsync_q <= cfg_wdata_i[2];
				halt_vsync_q <= cfg_wdata_i[3];
			end
			if (cfg_wen_i && cfg_addr_i == CFG_BG_COLOUR)
				default_colour_o <= cfg_wdata_i[14:0];
			if (cfg_wen_i && cfg_addr_i == CFG_DISP_W)
				disp_w_o <= cfg_wdata_i[8:0];
			if (cfg_wen_i && cfg_addr_i == CFG_DISP_H)
				disp_h_o <= cfg_wdata_i[8:0];
			// Auto-increment after each data write
			if (cfg_wen_i && cfg_addr_i == CFG_PAL_IDX)
				pal_ptr_q <= cfg_wdata_i[7:0];
			else if (pal_data_wr)
				pal_ptr_q <= pal_ptr_q + 8'd1;
		end
	end

	// Palette write payload
	always_ff @(posedge clk_ppu) begin
		if (pal_data_wr) begin
			pal_waddr_o <= pal_ptr_q;
			pal_wdata_o <= cfg_wdata_i[14:0];
		end
	end

	// ------------------------------
	// Run/halt FSM
	// ------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			PPU_IDLE: begin
				if (run_stb && !halt_stb)
					state_d = PPU_RUNNING;
			end
			PPU_RUNNING: begin
				// Halt wins over run; a fresh run keeps going past a sync stop
				if (halt_stb || (sync_stop && !run_stb))
					state_d = PPU_IDLE;
			end
			default: state_d = PPU_IDLE;
		endcase
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			state_q <= PPU_IDLE;
		else
			state_q <= state_d;
	end

	assign run_o = (state_q == PPU_RUNNING);

	// Writes only target mapped registers
	a_cfg_addr_mapped: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		cfg_wen_i |-> (cfg_addr_i <= CFG_PAL_DATA));

endmodule

/* rtl/ppu_core.sv */
// PPU pixel path top level
// Configuration decode, blender, palette mapper and raster counter
// joined into a two-stage pixel pipeline

`timescale 1ns/10ps

module ppu_core import ppu_pkg::*; #(
	parameter int N_LAYERS   = 4,
	parameter int PX_CREDITS = 4
) (
	input  logic                             clk_ppu,
	input  logic                             rst_n_ppu,

	input  logic                             cfg_wen_i,
	input  cfg_addr_t                        cfg_addr_i,
	input  cfg_data_t                        cfg_wdata_i,

	input  logic                             in_vld_i,
	output logic                             in_rdy_o,
	input  logic [N_LAYERS-1:0]              layer_alpha_i,
	input  logic [N_LAYERS-1:0]              layer_paletted_i,
	input  logic [N_LAYERS*$bits(pix_t)-1:0] layer_pix_i,

	output logic                             out_vld_o,
	output lcd_pix_t                         out_pix_o,
	input  logic                             credit_i,

	output logic                             running_o,
	output coord_t                           beam_x_o,
	output coord_t                           beam_y_o
);

	pix_t     default_colour;
	coord_t   disp_w;
	coord_t   disp_h;
	logic     pal_wen;
	pal_idx_t pal_waddr;
	pix_t     pal_wdata;
	logic     hsync;
	logic     vsync;

	// Execute to result
	logic     blend_vld;
	logic     blend_rdy;
	pix_t     blend_pix;
	logic     blend_paletted;

	logic     px_sent;

	ppu_cfg_decode cfg_decode_u (
		.clk_ppu          (clk_ppu),
		.rst_n_ppu        (rst_n_ppu),
		.cfg_wen_i        (cfg_wen_i),
		.cfg_addr_i       (cfg_addr_i),
		.cfg_wdata_i      (cfg_wdata_i),
		.hsync_i          (hsync),
		.vsync_i          (vsync),
		.run_o            (running_o),
		.default_colour_o (default_colour),
		.disp_w_o         (disp_w),
		.disp_h_o         (disp_h),
		.pal_wen_o        (pal_wen),
		.pal_waddr_o      (pal_waddr),
		.pal_wdata_o      (pal_wdata)
	);

	ppu_blender #(
		.N_LAYERS (N_LAYERS)
	) blender_u (
		.clk_ppu          (clk_ppu),
		.rst_n_ppu        (rst_n_ppu),
		.run_i            (running_o),
		.in_vld_i         (in_vld_i),
		.in_rdy_o         (in_rdy_o),
		.layer_alpha_i    (layer_alpha_i),
		.layer_paletted_i (layer_paletted_i),
		.layer_pix_i      (layer_pix_i),
		.default_colour_i (default_colour),
		.out_vld_o        (blend_vld),
		.out_rdy_i        (blend_rdy),
		.out_pix_o        (blend_pix),
		.out_paletted_o   (blend_paletted)
	);

	ppu_palette_mapper #(
		.PX_CREDITS (PX_CREDITS)
	) palette_mapper_u (
		.clk_ppu       (clk_ppu),
		.rst_n_ppu     (rst_n_ppu),
		.in_vld_i      (blend_vld),
		.in_rdy_o      (blend_rdy),
		.in_pix_i      (blend_pix),
		.in_paletted_i (blend_paletted),
		.pal_wen_i     (pal_wen),
		.pal_waddr_i   (pal_waddr),
		.pal_wdata_i   (pal_wdata),
		.out_vld_o     (out_vld_o),
		.out_pix_o     (out_pix_o),
		.credit_i      (credit_i),
		.px_sent_o     (px_sent)
	);

	ppu_raster_counter raster_counter_u (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.advance_i (px_sent),
		.disp_w_i  (disp_w),
		.disp_h_i  (disp_h),
		.beam_x_o  (beam_x_o),
		.beam_y_o  (beam_y_o),
		.hsync_o   (hsync),
		.vsync_o   (vsync)
	);

endmodule

/* rtl/ppu_palette_mapper.sv */
// PPU palette mapper, result stage
// Looks paletted pixels up in the 256-entry palette RAM, packs the
// colour to LCD format and sends it out under credit flow control

`timescale 1ns/10ps

module ppu_palette_mapper import ppu_pkg::*; #(
	parameter int PX_CREDITS = 4
) (
	input  logic     clk_ppu,
	input  logic     rst_n_ppu,

	input  logic     in_vld_i,
	output logic     in_rdy_o,
	input  pix_t     in_pix_i,
	input  logic     in_paletted_i,

	input  logic     pal_wen_i,
	input  pal_idx_t pal_waddr_i,
	input  pix_t     pal_wdata_i,

	output logic     out_vld_o,
	output lcd_pix_t out_pix_o,
	input  logic     credit_i,

	output logic     px_sent_o
);

	localparam int W_CREDIT = $clog2(PX_CREDITS + 1);

	pix_t pal_ram [256];

	logic                hold_vld_q;
	logic [W_CREDIT-1:0] credit_q;
	pix_t                colour;
	logic                take;

	// Insert a zero below the upper ten bits
	function automatic lcd_pix_t pack_lcd(input pix_t c);
		return {c[14:5], 1'b0, c[4:0]};
	endfunction

	// ------------------------------
	// Palette RAM
	// ------------------------------

	always_ff @(posedge clk_ppu) begin
		if (pal_wen_i)
			pal_ram[pal_waddr_i] <= pal_wdata_i;
	end

	assign colour = in_paletted_i ? pal_ram[in_pix_i[7:0]] : in_pix_i;

	// ------------------------------
	// Output register
	// ------------------------------

	// Empty, or its pixel leaves this cycle
	assign in_rdy_o = !hold_vld_q || out_vld_o;
	assign take     = in_vld_i && in_rdy_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			hold_vld_q <= 1'b0;
		else if (take)
			hold_vld_q <= 1'b1;
		else if (out_vld_o)
			hold_vld_q <= 1'b0;
	end

	always_ff @(posedge clk_ppu) begin
		if (take)
			out_pix_o <= pack_lcd(colour);
	end

	// ------------------------------
	// Credit accounting
	// ------------------------------

	assign out_vld_o = hold_vld_q && (credit_q != '0);
	assign px_sent_o = out_vld_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			credit_q <= W_CREDIT'(PX_CREDITS);
		end else begin
			case ({out_vld_o, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	// Consumer must not return more credits than pixels it got
	a_credit_max: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		credit_q <= W_CREDIT'(PX_CREDITS));

endmodule

/* rtl/ppu_pkg.sv */
// PPU pixel path shared definitions
// Pixel, coordinate and configuration types, the configuration
// register map and the run controller states

package ppu_pkg;

	// ------------------------------
	// Data types
	// ------------------------------

	// 5-5-5 colour as produced by a layer or the palette
	typedef logic [14:0] pix_t;

	// Colour in 16-bit LCD format
	typedef logic [15:0] lcd_pix_t;

	// Screen coordinate, display size or beam position
	typedef logic [8:0]  coord_t;

	// Palette index, low byte of a paletted pixel
	typedef logic [7:0]  pal_idx_t;

	typedef logic [2:0]  cfg_addr_t;
	typedef logic [15:0] cfg_data_t;

	// Run controller states
	typedef enum logic {
		PPU_IDLE    = 1'b0,
		PPU_RUNNING = 1'b1
	} ppu_state_e;

	// ------------------------------
	// Configuration register map
	// ------------------------------

	// CTRL bits: 0 run strobe, 1 halt strobe, 2 halt on hsync, 3 halt on vsync
	localparam cfg_addr_t CFG_CTRL      = 3'd0;
	localparam cfg_addr_t CFG_BG_COLOUR = 3'd1;
	// Sizes hold the last coordinate, i.e. size minus one
	localparam cfg_addr_t CFG_DISP_W    = 3'd2;
	localparam cfg_addr_t CFG_DISP_H    = 3'd3;
	localparam cfg_addr_t CFG_PAL_IDX   = 3'd4;
	localparam cfg_addr_t CFG_PAL_DATA  = 3'd5;

endpackage

/* rtl/ppu_raster_counter.sv */
// PPU raster counter
// Tracks the beam position of each pixel sent and flags the
// advances that start a new row or a new frame

`timescale 1ns/10ps

module ppu_raster_counter import ppu_pkg::*; (
	input  logic   clk_ppu,
	input  logic   rst_n_ppu,

	input  logic   advance_i,
	input  coord_t disp_w_i,
	input  coord_t disp_h_i,

	output coord_t beam_x_o,
	output coord_t beam_y_o,
	output logic   hsync_o,
	output logic   vsync_o
);

	logic x_last;
	logic y_last;

	// Compare with >= so a shrunk display size still wraps
	assign x_last = (beam_x_o >= disp_w_i);
	assign y_last = (beam_y_o >= disp_h_i);

	assign hsync_o = advance_i && x_last;
	assign vsync_o = hsync_o && y_last;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			beam_x_o <= '0;
			beam_y_o <= '0;
		end else if (advance_i) begin
			if (x_last) begin
				beam_x_o <= '0;
				if (y_last)
					beam_y_o <= '0;
				else
					beam_y_o <= beam_y_o + 1'b1;
			end else begin
				beam_x_o <= beam_x_o + 1'b1;
			end
		end
	end

endmodule
